// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_sram_dual_port
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
PASS_MSG  := Simulation PASSED

# Sources named in the file list plus the included table
SOURCES   := $(shell grep -v '^+' $(FILELIST)) tb/tb_sram_table.svh

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	grep -q "^$(PASS_MSG)$$" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// File: src/sram_array.sv
`timescale 1ns/1ps
`default_nettype none

// Grid of tiles, NUM_SLICES across the word and NUM_BANKS deep
// Each bank sees both ports, each port gets every bank's word back
module sram_array
  import sram_pkg::*;
(
  input  wire logic                                          clk_i,
  // Per port tile controls
  input  wire logic       [NUM_PORTS-1:0][NUM_BANKS-1:0]     bank_en_i,
  input  wire logic       [NUM_PORTS-1:0]                    we_i,
  input  wire sram_row_t  [NUM_PORTS-1:0]                    row_i,
  input  wire sram_word_u [NUM_PORTS-1:0]                    wdata_i,
  input  wire sram_be_t   [NUM_PORTS-1:0]                    be_i,
  // Read data of every bank, per port
  output sram_word_u      [NUM_PORTS-1:0][NUM_BANKS-1:0]     bank_rdata_o
);

  // Write data and byte enables cut into slice pieces
  wire [TILE_WIDTH-1:0] tile_wdata [NUM_PORTS][NUM_SLICES];
  wire [TILE_BYTES-1:0] tile_be    [NUM_PORTS][NUM_SLICES];

  // Raw tile outputs per port, bank and slice
  wire [TILE_WIDTH-1:0] tile_rdata [NUM_PORTS][NUM_BANKS][NUM_SLICES];

  // Slice each port's word along byte boundaries
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port_slice
    for (genvar s = 0; s < NUM_SLICES; s++) begin : gen_slice
      assign tile_wdata[p][s] = wdata_i[p].bytes[s*TILE_BYTES +: TILE_BYTES];
      assign tile_be[p][s]    = be_i[p][s*TILE_BYTES +: TILE_BYTES];
    end
  end

  // Depth cascade, every bank holds one row of tiles
  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    for (genvar s = 0; s < NUM_SLICES; s++) begin : gen_slice
      // Same enable and row on all slices of a bank
      sram_tile i_tile (
        .clk_i     (clk_i),
        .en_a_i    (bank_en_i[0][b]),
        .we_a_i    (we_i[0]),
        .row_a_i   (row_i[0]),
        .wdata_a_i (tile_wdata[0][s]),
        .be_a_i    (tile_be[0][s]),
        .rdata_a_o (tile_rdata[0][b][s]),
        .en_b_i    (bank_en_i[1][b]),
        .we_b_i    (we_i[1]),
        .row_b_i   (row_i[1]),
        .wdata_b_i (tile_wdata[1][s]),
        .be_b_i    (tile_be[1][s]),
        .rdata_b_o (tile_rdata[1][b][s])
      );
    end
  end

  // Put the slices of each bank back together into whole words
  always_comb begin
    bank_rdata_o = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        for (int s = 0; s < NUM_SLICES; s++) begin
          bank_rdata_o[p][b].bytes[s*TILE_BYTES +: TILE_BYTES] = tile_rdata[p][b][s];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/sram_dual_port.sv
`timescale 1ns/1ps
`default_nettype none

// Two port SRAM, NUM_WORDS by DATA_WIDTH with byte enables
// Read result appears two edges after the request and then holds
module sram_dual_port
  import sram_pkg::*;
(
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  // Request ports, no back pressure
  input  wire logic       [NUM_PORTS-1:0]    req_i,
  input  wire logic       [NUM_PORTS-1:0]    we_i,
  input  wire sram_addr_t [NUM_PORTS-1:0]    addr_i,
  input  wire sram_word_u [NUM_PORTS-1:0]    wdata_i,
  input  wire sram_be_t   [NUM_PORTS-1:0]    be_i,
  // Held read data per port
  output wire sram_word_u [NUM_PORTS-1:0]    rdata_o
);

  // Controller to array
  wire logic       [NUM_PORTS-1:0][NUM_BANKS-1:0] bank_en;
  wire logic       [NUM_PORTS-1:0]                arr_we;
  wire sram_row_t  [NUM_PORTS-1:0]                arr_row;
  wire sram_word_u [NUM_PORTS-1:0]                arr_wdata;
  wire sram_be_t   [NUM_PORTS-1:0]                arr_be;

  // Array back to controller, one word per bank
  wire sram_word_u [NUM_PORTS-1:0][NUM_BANKS-1:0] bank_rdata;

  // One controller per port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    sram_port_ctrl i_port_ctrl (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .req_i        (req_i[p]),
      .we_i         (we_i[p]),
      .addr_i       (addr_i[p]),
      .wdata_i      (wdata_i[p]),
      .be_i         (be_i[p]),
      .bank_en_o    (bank_en[p]),
      .we_o         (arr_we[p]),
      .row_o        (arr_row[p]),
      .wdata_o      (arr_wdata[p]),
      .be_o         (arr_be[p]),
      .bank_rdata_i (bank_rdata[p]),
      .rdata_o      (rdata_o[p])
    );
  end

  // Shared tile grid
  sram_array i_array (
    .clk_i        (clk_i),
    .bank_en_i    (bank_en),
    .we_i         (arr_we),
    .row_i        (arr_row),
    .wdata_i      (arr_wdata),
    .be_i         (arr_be),
    .bank_rdata_o (bank_rdata)
  );

endmodule

`default_nettype wire

// File: src/sram_pkg.sv
`default_nettype none

package sram_pkg;

  // Memory geometry as seen at the top level
  localparam int unsigned NUM_WORDS  = 1024;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BYTE_WIDTH = 8;
  localparam int unsigned NUM_BYTES  = DATA_WIDTH / BYTE_WIDTH;
  localparam int unsigned ADDR_WIDTH = $clog2(NUM_WORDS);

  // Tile geometry, one block RAM sized slice of the word and of the depth
  localparam int unsigned TILE_WIDTH = 16;
  localparam int unsigned TILE_BYTES = TILE_WIDTH / BYTE_WIDTH;
  localparam int unsigned TILE_DEPTH = 256;
  localparam int unsigned ROW_WIDTH  = $clog2(TILE_DEPTH);

  // Tiles side by side across the word, and stacked in depth
  localparam int unsigned NUM_SLICES = DATA_WIDTH / TILE_WIDTH;
  localparam int unsigned NUM_BANKS  = NUM_WORDS / TILE_DEPTH;

  // Independent request ports
  localparam int unsigned NUM_PORTS  = 2;

  // Word address, upper bits pick the bank, lower bits the tile row
  typedef logic [ADDR_WIDTH-1:0] sram_addr_t;
  typedef logic [ROW_WIDTH-1:0] sram_row_t;
  typedef logic [$clog2(NUM_BANKS)-1:0] sram_bank_t;

  // One enable per data byte
  typedef logic [NUM_BYTES-1:0] sram_be_t;

  // Data word, used whole on the ports and as bytes when slicing into tiles
  typedef union packed {
    logic [DATA_WIDTH-1:0] word;
    logic [NUM_BYTES-1:0][BYTE_WIDTH-1:0] bytes;
  } sram_word_u;

endpackage

`default_nettype wire

// File: src/sram_port_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// Front end of one port
// Decodes the bank, tracks the read in flight and holds the result
module sram_port_ctrl
  import sram_pkg::*;
(
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  // Request from outside, accepted whenever req_i is high
  input  wire logic                        req_i,
  input  wire logic                        we_i,
  input  wire sram_addr_t                  addr_i,
  input  wire sram_word_u                  wdata_i,
  input  wire sram_be_t                    be_i,
  // Towards the tile array
  output logic       [NUM_BANKS-1:0]       bank_en_o,
  output logic                             we_o,
  output sram_row_t                        row_o,
  output sram_word_u                       wdata_o,
  output sram_be_t                         be_o,
  input  wire sram_word_u [NUM_BANKS-1:0]  bank_rdata_i,
  // Held read result
  output sram_word_u                       rdata_o
);

  // Address split, bank on top
  sram_bank_t bank;
  logic       rd_req;

  // Read in flight, registered with the accepting edge
  logic       rd_valid_q;
  sram_bank_t rd_bank_q;

  // Output word, only replaced by a new read result
  sram_word_u rdata_q;

  assign bank   = addr_i[ADDR_WIDTH-1 -: $bits(sram_bank_t)];
  assign rd_req = req_i & ~we_i;

  // One hot bank select, nothing enabled without a request
  always_comb begin
    bank_en_o       = '0;
    bank_en_o[bank] = req_i;
  end

  // Row inside the bank and write payload
  assign row_o   = addr_i[ROW_WIDTH-1:0];
  assign we_o    = req_i & we_i;
  assign wdata_o = wdata_i;
  assign be_o    = be_i;

  // Remember which bank answers the read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= 1'b0;
      rd_bank_q  <= '0;
    end else begin
      rd_valid_q <= rd_req;
      // Bank only moves on a read so it stays stable otherwise
      if (rd_req) begin
        rd_bank_q <= bank;
      end
    end
  end

  // Tile data is valid one edge after the read was accepted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (rd_valid_q) begin
      rdata_q <= bank_rdata_i[rd_bank_q];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: src/sram_tile.sv
`timescale 1ns/1ps
`default_nettype none

// One storage tile, TILE_DEPTH rows of TILE_WIDTH bits
// Two symmetric ports, each reads or writes on an enabled edge
module sram_tile
  import sram_pkg::*;
(
  input  wire logic                  clk_i,
  // Port A
  input  wire logic                  en_a_i,
  input  wire logic                  we_a_i,
  input  wire sram_row_t             row_a_i,
  input  wire logic [TILE_WIDTH-1:0] wdata_a_i,
  input  wire logic [TILE_BYTES-1:0] be_a_i,
  output logic      [TILE_WIDTH-1:0] rdata_a_o,
  // Port B
  input  wire logic                  en_b_i,
  input  wire logic                  we_b_i,
  input  wire sram_row_t             row_b_i,
  input  wire logic [TILE_WIDTH-1:0] wdata_b_i,
  input  wire logic [TILE_BYTES-1:0] be_b_i,
  output logic      [TILE_WIDTH-1:0] rdata_b_o
);

  // Storage kept as bytes so a byte enable maps onto one entry lane
  logic [TILE_BYTES-1:0][BYTE_WIDTH-1:0] mem_q [TILE_DEPTH];

  // Both ports gathered into arrays, index 0 is A and 1 is B
  logic [NUM_PORTS-1:0]  en;
  logic [NUM_PORTS-1:0]  we;
  sram_row_t             row   [NUM_PORTS];
  logic [TILE_WIDTH-1:0] wdata [NUM_PORTS];
  logic [TILE_BYTES-1:0] be    [NUM_PORTS];

  // Per port read register, like the block RAM output latch
  logic [TILE_WIDTH-1:0] rdata_q [NUM_PORTS];

  always_comb begin
    en[0]    = en_a_i;
    we[0]    = we_a_i;
    row[0]   = row_a_i;
    wdata[0] = wdata_a_i;
    be[0]    = be_a_i;
    en[1]    = en_b_i;
    we[1]    = we_b_i;
    row[1]   = row_b_i;
    wdata[1] = wdata_b_i;
    be[1]    = be_b_i;
  end

  // Single process for both ports
  // Port B is handled last, so it wins a same row write collision
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (en[p]) begin
        if (we[p]) begin
          // Byte masked write, read register keeps its old value
          for (int i = 0; i < TILE_BYTES; i++) begin
            if (be[p][i]) begin
              mem_q[row[p]][i] <= wdata[p][i*BYTE_WIDTH +: BYTE_WIDTH];
            end
          end
        end else begin
          // Read returns contents from before this edge
          rdata_q[p] <= mem_q[row[p]];
        end
      end
    end
  end

  // Read data stays until the next read on the same port
  assign rdata_a_o = rdata_q[0];
  assign rdata_b_o = rdata_q[1];

endmodule

`default_nettype wire

// File: tb/tb_sram_table.svh
// Stimulus and expectation table, one row per clock cycle
// Columns of set_op: row, port, req, we, addr, wdata, be, chk, exp
// With chk set, rdata_o of that port must equal exp once the row's read is back

localparam int unsigned NUM_ROWS = 30;

logic       tbl_req   [NUM_ROWS][NUM_PORTS];
logic       tbl_we    [NUM_ROWS][NUM_PORTS];
sram_addr_t tbl_addr  [NUM_ROWS][NUM_PORTS];
sram_word_u tbl_wdata [NUM_ROWS][NUM_PORTS];
sram_be_t   tbl_be    [NUM_ROWS][NUM_PORTS];
logic       tbl_chk   [NUM_ROWS][NUM_PORTS];
sram_word_u tbl_exp   [NUM_ROWS][NUM_PORTS];

// Fill one port entry of one row
task automatic set_op(input int unsigned row, input int unsigned port, input logic req,
                      input logic we, input sram_addr_t addr, input sram_word_u wdata,
                      input sram_be_t be, input logic chk, input sram_word_u exp);
  tbl_req[row][port]   = req;
  tbl_we[row][port]    = we;
  tbl_addr[row][port]  = addr;
  tbl_wdata[row][port] = wdata;
  tbl_be[row][port]    = be;
  tbl_chk[row][port]   = chk;
  tbl_exp[row][port]   = exp;
endtask

task automatic load_table();
  // Every entry idle and unchecked unless set below
  for (int r = 0; r < NUM_ROWS; r++) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      set_op(r, p, 1'b0, 1'b0, '0, '0, '0, 1'b0, '0);
    end
  end
  // Nothing read yet, outputs still at their reset value
  set_op( 0, 0, 1'b0, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'h0000_0000);
  set_op( 0, 1, 1'b0, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'h0000_0000);
  set_op( 1, 0, 1'b0, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'h0000_0000);
  set_op( 1, 1, 1'b0, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'h0000_0000);
  // Full words into all four banks, both bank edges
  set_op( 2, 0, 1'b1, 1'b1, 10'h000, 32'h1122_3344, 4'b1111, 1'b0, 32'h0);
  set_op( 2, 1, 1'b1, 1'b1, 10'h0ff, 32'hA5A5_0FF0, 4'b1111, 1'b0, 32'h0);
  set_op( 3, 0, 1'b1, 1'b1, 10'h100, 32'h0100_CAFE, 4'b1111, 1'b0, 32'h0);
  set_op( 3, 1, 1'b1, 1'b1, 10'h1ff, 32'h1FF0_BEEF, 4'b1111, 1'b0, 32'h0);
  set_op( 4, 0, 1'b1, 1'b1, 10'h200, 32'h2000_D00D, 4'b1111, 1'b0, 32'h0);
  set_op( 4, 1, 1'b1, 1'b1, 10'h3ff, 32'h3FF3_FACE, 4'b1111, 1'b0, 32'h0);
  set_op( 5, 0, 1'b1, 1'b1, 10'h2ab, 32'h2AB0_1234, 4'b1111, 1'b0, 32'h0);
  set_op( 5, 1, 1'b1, 1'b1, 10'h37c, 32'h37C0_5678, 4'b1111, 1'b0, 32'h0);
  // Read back on the writing port, back to back
  set_op( 6, 0, 1'b1, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'h1122_3344);
  set_op( 6, 1, 1'b1, 1'b0, 10'h0ff, 32'h0, 4'b0000, 1'b1, 32'hA5A5_0FF0);
  set_op( 7, 0, 1'b1, 1'b0, 10'h100, 32'h0, 4'b0000, 1'b1, 32'h0100_CAFE);
  set_op( 7, 1, 1'b1, 1'b0, 10'h1ff, 32'h0, 4'b0000, 1'b1, 32'h1FF0_BEEF);
  set_op( 8, 0, 1'b1, 1'b0, 10'h200, 32'h0, 4'b0000, 1'b1, 32'h2000_D00D);
  set_op( 8, 1, 1'b1, 1'b0, 10'h3ff, 32'h0, 4'b0000, 1'b1, 32'h3FF3_FACE);
  set_op( 9, 0, 1'b1, 1'b0, 10'h2ab, 32'h0, 4'b0000, 1'b1, 32'h2AB0_1234);
  set_op( 9, 1, 1'b1, 1'b0, 10'h37c, 32'h0, 4'b0000, 1'b1, 32'h37C0_5678);
  // Same words read through the other port
  set_op(10, 0, 1'b1, 1'b0, 10'h3ff, 32'h0, 4'b0000, 1'b1, 32'h3FF3_FACE);
  set_op(10, 1, 1'b1, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'h1122_3344);
  set_op(11, 0, 1'b1, 1'b0, 10'h37c, 32'h0, 4'b0000, 1'b1, 32'h37C0_5678);
  set_op(11, 1, 1'b1, 1'b0, 10'h100, 32'h0, 4'b0000, 1'b1, 32'h0100_CAFE);
  set_op(12, 0, 1'b1, 1'b0, 10'h0ff, 32'h0, 4'b0000, 1'b1, 32'hA5A5_0FF0);
  set_op(12, 1, 1'b1, 1'b0, 10'h200, 32'h0, 4'b0000, 1'b1, 32'h2000_D00D);
  set_op(13, 0, 1'b1, 1'b0, 10'h1ff, 32'h0, 4'b0000, 1'b1, 32'h1FF0_BEEF);
  set_op(13, 1, 1'b1, 1'b0, 10'h2ab, 32'h0, 4'b0000, 1'b1, 32'h2AB0_1234);
  // Partial writes, old word with enabled bytes replaced
  set_op(14, 0, 1'b1, 1'b1, 10'h000, 32'hFFEE_DDCC, 4'b0001, 1'b0, 32'h0);
  set_op(14, 1, 1'b1, 1'b1, 10'h0ff, 32'h9988_7766, 4'b0110, 1'b0, 32'h0);
  set_op(15, 0, 1'b1, 1'b1, 10'h200, 32'h55AA_55AA, 4'b1010, 1'b0, 32'h0);
  set_op(15, 1, 1'b1, 1'b1, 10'h3ff, 32'h0BAD_F00D, 4'b1100, 1'b0, 32'h0);
  set_op(16, 0, 1'b1, 1'b1, 10'h100, 32'h1234_5678, 4'b0000, 1'b0, 32'h0);
  set_op(16, 1, 1'b1, 1'b1, 10'h1ff, 32'h600D_F00D, 4'b1001, 1'b0, 32'h0);
  set_op(17, 0, 1'b1, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'h1122_33CC);
  set_op(17, 1, 1'b1, 1'b0, 10'h0ff, 32'h0, 4'b0000, 1'b1, 32'hA588_77F0);
  set_op(18, 0, 1'b1, 1'b0, 10'h200, 32'h0, 4'b0000, 1'b1, 32'h5500_550D);
  set_op(18, 1, 1'b1, 1'b0, 10'h3ff, 32'h0, 4'b0000, 1'b1, 32'h0BAD_FACE);
  // No enables set, word untouched
  set_op(19, 0, 1'b1, 1'b0, 10'h100, 32'h0, 4'b0000, 1'b1, 32'h0100_CAFE);
  set_op(19, 1, 1'b1, 1'b0, 10'h1ff, 32'h0, 4'b0000, 1'b1, 32'h60F0_BE0D);
  // Port 0 writes while port 1 reads elsewhere, then read across ports
  set_op(20, 0, 1'b1, 1'b1, 10'h2ab, 32'hCAFE_BABE, 4'b1111, 1'b0, 32'h0);
  set_op(20, 1, 1'b1, 1'b0, 10'h37c, 32'h0, 4'b0000, 1'b1, 32'h37C0_5678);
  set_op(21, 0, 1'b1, 1'b1, 10'h0aa, 32'h0A0A_0A0A, 4'b1111, 1'b0, 32'h0);
  set_op(21, 1, 1'b1, 1'b0, 10'h2ab, 32'h0, 4'b0000, 1'b1, 32'hCAFE_BABE);
  set_op(22, 0, 1'b1, 1'b0, 10'h2ab, 32'h0, 4'b0000, 1'b1, 32'hCAFE_BABE);
  set_op(22, 1, 1'b1, 1'b0, 10'h0aa, 32'h0, 4'b0000, 1'b1, 32'h0A0A_0A0A);
  set_op(23, 0, 1'b1, 1'b0, 10'h0aa, 32'h0, 4'b0000, 1'b1, 32'h0A0A_0A0A);
  set_op(23, 1, 1'b1, 1'b0, 10'h37c, 32'h0, 4'b0000, 1'b1, 32'h37C0_5678);
  // Held across idle and across writes on the same port
  set_op(24, 0, 1'b0, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'h0A0A_0A0A);
  set_op(24, 1, 1'b0, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'h37C0_5678);
  set_op(25, 0, 1'b1, 1'b1, 10'h0aa, 32'hFFFF_FFFF, 4'b1111, 1'b1, 32'h0A0A_0A0A);
  set_op(25, 1, 1'b1, 1'b1, 10'h37c, 32'h0000_0000, 4'b1111, 1'b1, 32'h37C0_5678);
  set_op(26, 0, 1'b0, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'h0A0A_0A0A);
  set_op(26, 1, 1'b0, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'h37C0_5678);
  set_op(27, 0, 1'b1, 1'b0, 10'h0aa, 32'h0, 4'b0000, 1'b1, 32'hFFFF_FFFF);
  set_op(27, 1, 1'b1, 1'b0, 10'h37c, 32'h0, 4'b0000, 1'b1, 32'h0000_0000);
  set_op(28, 0, 1'b0, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'hFFFF_FFFF);
  set_op(28, 1, 1'b0, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'h0000_0000);
  set_op(29, 0, 1'b0, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'hFFFF_FFFF);
  set_op(29, 1, 1'b0, 1'b0, 10'h000, 32'h0, 4'b0000, 1'b1, 32'h0000_0000);
endtask

// File: tb/tb_sram_dual_port.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the two port SRAM
// One table row per clock, each checked row compared once its read is back
module tb_sram_dual_port
  import sram_pkg::*;
();

  localparam int unsigned CLK_PERIOD_NS = 10;
  localparam int unsigned RESET_CYCLES  = 16;
  // Row driven after edge N, accepted at N+1, visible after N+2
  localparam int unsigned CHECK_DELAY   = 2;

  logic                             clk_i;
  logic                             rst_ni;
  logic       [NUM_PORTS-1:0]       req_i;
  logic       [NUM_PORTS-1:0]       we_i;
  sram_addr_t [NUM_PORTS-1:0]       addr_i;
  sram_word_u [NUM_PORTS-1:0]       wdata_i;
  sram_be_t   [NUM_PORTS-1:0]       be_i;
  wire sram_word_u [NUM_PORTS-1:0]  rdata_o;

  // Expected words waiting for their read, tagged by table row
  int unsigned pend_row [NUM_PORTS][$];
  sram_word_u  pend_exp [NUM_PORTS][$];

  `include "tb_sram_table.svh"

  sram_dual_port sram_dual_port_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .be_i    (be_i),
    .rdata_o (rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
  end

  // Watchdog sized from reset, table length and some slack
  initial begin
    int unsigned limit_ns;
    limit_ns = (RESET_CYCLES + NUM_ROWS + 10) * CLK_PERIOD_NS;
    #(limit_ns);
    $display("Simulation did not finish within %0d ns", limit_ns);
    $display("Simulation FAILED");
    $fatal(1, "Watchdog expired");
  end

  // Compare one read word against its expected value
  task automatic check_word(input string name, input sram_word_u got,
                            input sram_word_u exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h exp %h", name, got.word, exp.word);
      $display("Simulation FAILED");
      $fatal(1, "Read data mismatch");
    end
  endtask

  // Put one table row on the ports, idle past the end of the table
  task automatic drive_row(input int unsigned i);
    logic       [NUM_PORTS-1:0] req;
    logic       [NUM_PORTS-1:0] we;
    sram_addr_t [NUM_PORTS-1:0] addr;
    sram_word_u [NUM_PORTS-1:0] wdata;
    sram_be_t   [NUM_PORTS-1:0] be;
    req   = '0;
    we    = '0;
    addr  = '0;
    wdata = '0;
    be    = '0;
    if (i < NUM_ROWS) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        req[p]   = tbl_req[i][p];
        we[p]    = tbl_we[i][p];
        addr[p]  = tbl_addr[i][p];
        wdata[p] = tbl_wdata[i][p];
        be[p]    = tbl_be[i][p];
        if (tbl_chk[i][p]) begin
          pend_row[p].push_back(i);
          pend_exp[p].push_back(tbl_exp[i][p]);
        end
      end
    end
    req_i   <= req;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    be_i    <= be;
  endtask

  // Pop and check every entry whose result is visible at loop step j
  task automatic check_due(input int unsigned j);
    int unsigned row;
    sram_word_u  exp;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (pend_row[p].size() != 0 && pend_row[p][0] + CHECK_DELAY == j) begin
        row = pend_row[p].pop_front();
        exp = pend_exp[p].pop_front();
        check_word($sformatf("rdata_o[%0d] (row %0d)", p, row), rdata_o[p], exp);
      end
    end
  endtask

  initial begin
    // Ports idle and reset held from time zero
    rst_ni  <= 1'b0;
    req_i   <= '0;
    we_i    <= '0;
    addr_i  <= '0;
    wdata_i <= '0;
    be_i    <= '0;
    load_table();
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Drive on the rising edge, sample on the falling edge
    for (int unsigned i = 0; i < NUM_ROWS + CHECK_DELAY; i++) begin
      @(posedge clk_i);
      drive_row(i);
      @(negedge clk_i);
      check_due(i);
    end
    if (pend_row[0].size() == 0 && pend_row[1].size() == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Some expected read results were never compared");
      $display("Simulation FAILED");
      $fatal(1, "Checks left pending");
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+tb
src/sram_pkg.sv
src/sram_tile.sv
src/sram_array.sv
src/sram_port_ctrl.sv
src/sram_dual_port.sv
tb/tb_sram_dual_port.sv
